//--- common/merge_pkg.sv
// Shared definitions for the merge-data engine
// Widths, FIFO sizing, operation codes, config word fields and FSM states

package merge_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int num_lanes   = 2;
    localparam int word_width  = 32;
    localparam int count_width = 16;
    localparam int op_width    = 2;

    // FIFO sizing with prog_full headroom for words in flight
    localparam int fifo_depth  = 16;
    localparam int prog_thresh = 12;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef logic [word_width-1:0]  lane_data_t;
    typedef logic [word_width-1:0]  merge_word_t;
    typedef logic [count_width-1:0] merge_count_t;
    typedef logic [op_width-1:0]    merge_op_t;

    // Merge operation codes (2 and 3 fall back to pack)
    localparam merge_op_t op_pack = 2'd0;
    localparam merge_op_t op_sum  = 2'd1;

    // Config word layout
    localparam int cfg_count_lsb = 0;
    localparam int cfg_op_lsb    = 16;

    // Job FSM
    typedef enum logic [1:0] {
        st_idle,
        st_config,
        st_merge,
        st_done
    } merge_state_e;

endpackage

//--- hw/merge_fifo.sv
// Synchronous show-ahead FIFO
// Circular buffer with occupancy counter, empty and programmable-full flags

module merge_fifo #(
    parameter int depth  = merge_pkg::fifo_depth,
    parameter int width  = $bits(merge_pkg::merge_word_t),
    parameter int thresh = merge_pkg::prog_thresh
) (
    input  logic             ap_clk,
    input  logic             areset_csr_engine,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             empty,
    output logic             prog_full
);

    localparam int ptr_width  = (depth > 1) ? $clog2(depth) : 1;
    localparam int fill_width = $clog2(depth + 1);

    logic [width-1:0]      mem [depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [fill_width-1:0] fill;
    logic                  full;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head of queue is always visible
    assign dout = mem[rd_ptr];

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    assign empty     = (fill == '0);
    assign full      = (fill == fill_width'(depth));
    assign prog_full = (fill >= fill_width'(thresh));

    // Writers are expected to honour prog_full well before the last slot
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        full |-> !wr_en)
        else $error("merge_fifo: write while full");

    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        empty |-> !rd_en)
        else $error("merge_fifo: read while empty");

endmodule

//--- merge_engine/merge_count_timer.sv
// Remaining-packet down-counter
// Loaded per job, decremented per fire, flags last item and zero

module merge_count_timer (
    input  logic                    ap_clk,
    input  logic                    areset_csr_engine,
    input  logic                    load,
    input  merge_pkg::merge_count_t count,
    input  logic                    merge_fire,
    output logic                    last_item,
    output logic                    count_zero
);
    import merge_pkg::*;

    merge_count_t remaining;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count;
        end else if (merge_fire) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign last_item  = (remaining == merge_count_t'(1));
    assign count_zero = (remaining == '0);

    // FSM gating must stop the data path before the count runs out
    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        merge_fire |-> !count_zero)
        else $error("merge_count_timer: fire with count at zero");

endmodule

//--- merge_engine/merge_data_path.sv
// Merge data path
// Fire decision, lane pops, pack or sum of the lane words and the
// result register that feeds the output FIFO

module merge_data_path (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  logic                   merge_en,
    input  merge_pkg::merge_op_t   op,
    input  merge_pkg::lane_data_t  lane0_data,
    input  merge_pkg::lane_data_t  lane1_data,
    input  logic                   lane0_empty,
    input  logic                   lane1_empty,
    input  logic                   req_prog_full,
    output logic                   lane_pop,
    output logic                   merge_fire,
    output logic                   result_valid,
    output merge_pkg::merge_word_t result_data,
    output logic                   result_pending
);
    import merge_pkg::*;

    logic [num_lanes-1:0] lane_avail;
    merge_word_t          pack_word;
    merge_word_t          merged;

    // ------------------------------------------------------------------------
    // Fire when every lane has a word and the output has room
    // ------------------------------------------------------------------------
    assign lane_avail = {~lane1_empty, ~lane0_empty};
    assign merge_fire = merge_en && (&lane_avail) && !req_prog_full;
    assign lane_pop   = merge_fire;

    // Lane 1 low half on top
    assign pack_word = {lane1_data[15:0], lane0_data[15:0]};

    always_comb begin
        case (op)
            op_sum:  merged = lane0_data + lane1_data;
            op_pack: merged = pack_word;
            default: merged = pack_word;
        endcase
    end

    // ------------------------------------------------------------------------
    // Result register pushed into the output FIFO on the next cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= merge_fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (merge_fire) begin
            result_data <= merged;
        end
    end

    // A registered result is still on its way to the FIFO
    assign result_pending = result_valid;

    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        lane_pop |-> !$isunknown({op, lane0_data, lane1_data}))
        else $error("merge_data_path: pop with an unknown operation or lane word");

endmodule

//--- merge_engine/merge_control_fsm.sv
// Job FSM for the merge engine
// Takes the config word, loads the count timer, gates merging and
// raises done after the last result has reached the output FIFO

module merge_control_fsm (
    input  logic                    ap_clk,
    input  logic                    areset_csr_engine,
    input  logic                    start,
    input  logic                    cfg_empty,
    input  merge_pkg::merge_word_t  cfg_word,
    output logic                    cfg_pop,
    output logic                    load,
    output merge_pkg::merge_count_t count,
    output merge_pkg::merge_op_t    op,
    output logic                    merge_en,
    input  logic                    count_zero,
    input  logic                    last_item,
    input  logic                    merge_fire,
    input  logic                    result_pending,
    output logic                    done
);
    import merge_pkg::*;

    merge_state_e state;
    merge_state_e state_next;

    // Config FIFO is show-ahead, so the fields are valid in the pop cycle
    assign cfg_pop  = (state == st_config) && !cfg_empty;
    assign load     = cfg_pop;
    assign count    = cfg_word[cfg_count_lsb +: count_width];
    assign merge_en = (state == st_merge) && !count_zero;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_config;
                end
            end
            st_config: begin
                if (cfg_pop) begin
                    state_next = st_merge;
                end
            end
            st_merge: begin
                // Zero-length job leaves straight away
                if (count_zero || (merge_fire && last_item)) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                if (!result_pending) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state <= st_idle;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            if ((state == st_idle) && start) begin
                done <= 1'b0;
            end else if ((state == st_done) && !result_pending) begin
                done <= 1'b1;
            end
        end
    end

    // Operation held for the whole job
    always_ff @(posedge ap_clk) begin
        if (cfg_pop) begin
            op <= cfg_word[cfg_op_lsb +: op_width];
        end
    end

    assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        cfg_pop |-> !done)
        else $error("merge_control_fsm: config pop while done is high");

endmodule

//--- hw/merge_data_engine.sv
// Merge-data engine top level
// Two lane FIFOs, config FIFO, output request FIFO, job FSM, count timer
// and merge data path

module merge_data_engine (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    input  logic                   lane_valid_0,
    input  merge_pkg::lane_data_t  lane_data_0,
    output logic                   lane_ready_0,
    input  logic                   lane_valid_1,
    input  merge_pkg::lane_data_t  lane_data_1,
    output logic                   lane_ready_1,
    input  logic                   mem_valid,
    input  merge_pkg::merge_word_t mem_data,
    output logic                   mem_ready,
    output logic                   request_valid,
    output merge_pkg::merge_word_t request_data,
    input  logic                   request_ready,
    input  logic                   start,
    output logic                   done
);
    import merge_pkg::*;

    lane_data_t   lane0_dout;
    lane_data_t   lane1_dout;
    logic         lane0_empty;
    logic         lane1_empty;
    logic         lane0_prog_full;
    logic         lane1_prog_full;
    logic         lane_pop;
    merge_word_t  cfg_word;
    logic         cfg_empty;
    logic         cfg_prog_full;
    logic         cfg_pop;
    logic         req_empty;
    logic         req_prog_full;
    logic         req_pop;
    logic         load;
    merge_count_t count;
    merge_op_t    op;
    logic         merge_en;
    logic         merge_fire;
    logic         last_item;
    logic         count_zero;
    logic         result_valid;
    merge_word_t  result_data;
    logic         result_pending;

    // ------------------------------------------------------------------------
    // Input and output FIFOs
    // ------------------------------------------------------------------------
    merge_fifo #(.depth(fifo_depth), .width($bits(lane_data_t)), .thresh(prog_thresh))
    u_lane0_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en(lane_valid_0), .din(lane_data_0),
        .rd_en(lane_pop), .dout(lane0_dout), .empty(lane0_empty), .prog_full(lane0_prog_full)
    );

    merge_fifo #(.depth(fifo_depth), .width($bits(lane_data_t)), .thresh(prog_thresh))
    u_lane1_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en(lane_valid_1), .din(lane_data_1),
        .rd_en(lane_pop), .dout(lane1_dout), .empty(lane1_empty), .prog_full(lane1_prog_full)
    );

    merge_fifo #(.depth(fifo_depth), .width($bits(merge_word_t)), .thresh(prog_thresh))
    u_mem_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en(mem_valid), .din(mem_data),
        .rd_en(cfg_pop), .dout(cfg_word), .empty(cfg_empty), .prog_full(cfg_prog_full)
    );

    merge_fifo #(.depth(fifo_depth), .width($bits(merge_word_t)), .thresh(prog_thresh))
    u_req_fifo (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .wr_en(result_valid), .din(result_data),
        .rd_en(req_pop), .dout(request_data), .empty(req_empty), .prog_full(req_prog_full)
    );

    assign lane_ready_0  = ~lane0_prog_full;
    assign lane_ready_1  = ~lane1_prog_full;
    assign mem_ready     = ~cfg_prog_full;
    assign request_valid = ~req_empty;
    assign req_pop       = request_valid & request_ready;

    // ------------------------------------------------------------------------
    // Merge block
    // ------------------------------------------------------------------------
    merge_control_fsm u_control_fsm (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .start(start), .cfg_empty(cfg_empty), .cfg_word(cfg_word), .cfg_pop(cfg_pop),
        .load(load), .count(count), .op(op), .merge_en(merge_en),
        .count_zero(count_zero), .last_item(last_item), .merge_fire(merge_fire),
        .result_pending(result_pending), .done(done)
    );

    merge_count_timer u_count_timer (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .load(load), .count(count), .merge_fire(merge_fire),
        .last_item(last_item), .count_zero(count_zero)
    );

    merge_data_path u_data_path (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .merge_en(merge_en), .op(op),
        .lane0_data(lane0_dout), .lane1_data(lane1_dout),
        .lane0_empty(lane0_empty), .lane1_empty(lane1_empty), .req_prog_full(req_prog_full),
        .lane_pop(lane_pop), .merge_fire(merge_fire),
        .result_valid(result_valid), .result_data(result_data),
        .result_pending(result_pending)
    );

endmodule

//--- testbench/tb_merge_data_engine.sv
// Testbench for the merge-data engine
// Clock and reset, file-driven jobs, random output stalls and result checking

module tb_merge_data_engine;

    logic        ap_clk;
    logic        areset_csr_engine;
    logic        lane_valid_0;
    logic [31:0] lane_data_0;
    logic        lane_ready_0;
    logic        lane_valid_1;
    logic [31:0] lane_data_1;
    logic        lane_ready_1;
    logic        mem_valid;
    logic [31:0] mem_data;
    logic        mem_ready;
    logic        request_valid;
    logic [31:0] request_data;
    logic        request_ready;
    logic        start;
    logic        done;

    int          fd;
    int          code;
    int          rc;
    int          job;
    int          item_count;
    int          mode;
    logic [31:0] cfg;
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] we;
    logic [31:0] lfsr;
    logic [31:0] lane0_q[$];
    logic [31:0] lane1_q[$];
    logic [31:0] expect_q[$];

    merge_data_engine UUT (
        .ap_clk(ap_clk), .areset_csr_engine(areset_csr_engine),
        .lane_valid_0(lane_valid_0), .lane_data_0(lane_data_0), .lane_ready_0(lane_ready_0),
        .lane_valid_1(lane_valid_1), .lane_data_1(lane_data_1), .lane_ready_1(lane_ready_1),
        .mem_valid(mem_valid), .mem_data(mem_data), .mem_ready(mem_ready),
        .request_valid(request_valid), .request_data(request_data),
        .request_ready(request_ready), .start(start), .done(done)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #4 ap_clk = ~ap_clk;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display(">>> FAIL");
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display(">>> FAIL");
        $display("%s", reason);
        $fatal(1);
    endtask

    // Next record letter after blanks and comment lines
    task automatic read_code(output int c);
        c = $fgetc(fd);
        while (c == " " || c == "\n" || c == "\r" || c == "\t" || c == "#") begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end
            c = $fgetc(fd);
        end
    endtask

    task automatic push_pair(input int idx);
        lane_valid_0 = 1'b1;
        lane_valid_1 = 1'b1;
        lane_data_0  = lane0_q[idx];
        lane_data_1  = lane1_q[idx];
    endtask

    // ------------------------------------------------------------------------
    // Job sequence of config word, optional prefill, start, push and drain
    // ------------------------------------------------------------------------
    task automatic run_job();
        int pushed;
        int got;
        int cycles;
        pushed = 0;
        got    = 0;
        cycles = 0;
        check_value($sformatf("job%0d_mem_ready", job), 1, mem_ready);
        mem_valid = 1'b1;
        mem_data  = cfg;
        @(negedge ap_clk);
        mem_valid = 1'b0;
        // Lanes fill while the output is held off
        if (mode == 2) begin
            request_ready = 1'b0;
            while (lane_ready_0 && lane_ready_1 && pushed < item_count) begin
                push_pair(pushed);
                pushed++;
                @(negedge ap_clk);
            end
            lane_valid_0 = 1'b0;
            lane_valid_1 = 1'b0;
            check_value($sformatf("job%0d_prefill_depth", job), 12, pushed);
            check_value($sformatf("job%0d_lane_ready_0", job), 0, lane_ready_0);
        end
        start = 1'b1;
        @(negedge ap_clk);
        start = 1'b0;
        while (!(got == item_count && done)) begin
            if (pushed < item_count && lane_ready_0 && lane_ready_1) begin
                push_pair(pushed);
                pushed++;
            end else begin
                lane_valid_0 = 1'b0;
                lane_valid_1 = 1'b0;
            end
            case (mode)
                1: begin
                    lfsr          = lfsr_next(lfsr);
                    request_ready = lfsr[0];
                end
                2: request_ready = (pushed == item_count);
                default: request_ready = 1'b1;
            endcase
            if (request_valid && got >= item_count) begin
                abort_run($sformatf("Job %0d produced more results than expected", job));
            end
            if (done && got < item_count) begin
                check_value($sformatf("job%0d_done_after_last", job), 1, request_valid);
            end
            if (request_valid && request_ready) begin
                check_value($sformatf("job%0d_item%0d", job, got), expect_q[got], request_data);
                got++;
            end
            cycles++;
            if (cycles > 400) begin
                abort_run($sformatf("Timeout: job %0d did not finish within 400 cycles", job));
            end
            @(negedge ap_clk);
        end
        lane_valid_0 = 1'b0;
        lane_valid_1 = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        areset_csr_engine = 1'b1;
        lane_valid_0  = 1'b0;
        lane_valid_1  = 1'b0;
        lane_data_0   = '0;
        lane_data_1   = '0;
        mem_valid     = 1'b0;
        mem_data      = '0;
        request_ready = 1'b1;
        start         = 1'b0;
        lfsr          = 32'h17c2;
        job           = 0;
        repeat (5) @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        @(negedge ap_clk);
        check_value("reset_request_valid", 0, request_valid);
        check_value("reset_done", 0, done);
        check_value("reset_lane_ready_0", 1, lane_ready_0);
        check_value("reset_lane_ready_1", 1, lane_ready_1);
        check_value("reset_mem_ready", 1, mem_ready);
        fd = $fopen("testbench/merge_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open testbench/merge_stimulus.txt");
        end
        read_code(code);
        while (code != -1) begin
            if (code != "J") begin
                abort_run("Stimulus file has a record where a job was expected");
            end
            rc = $fscanf(fd, "%h %d %d", cfg, item_count, mode);
            if (rc != 3) begin
                abort_run("Stimulus file has an incomplete job record");
            end
            lane0_q.delete();
            lane1_q.delete();
            expect_q.delete();
            for (int i = 0; i < item_count; i++) begin
                read_code(code);
                if (code != "D") begin
                    abort_run("Stimulus file is missing a lane data record");
                end
                rc = $fscanf(fd, "%h %h %h", w0, w1, we);
                if (rc != 3) begin
                    abort_run("Stimulus file has an incomplete lane data record");
                end
                lane0_q.push_back(w0);
                lane1_q.push_back(w1);
                expect_q.push_back(we);
            end
            run_job();
            job++;
            read_code(code);
        end
        $fclose(fd);
        check_value("jobs_run", 4, job);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- testbench/merge_stimulus.txt
# J <config word hex> <item count> <mode: 0 steady, 1 random stalls, 2 back-pressure>
# D <lane 0 word hex> <lane 1 word hex> <expected result hex>
J 00000004 4 0
D a5a51234 0f0f5678 56781234
D 00000001 ffff0002 00020001
D deadbeef cafef00d f00dbeef
D 12345678 9abcdef0 def05678
J 00010006 6 1
D 00000001 00000002 00000003
D ffffffff 00000001 00000000
D 80000000 80000005 00000005
D 12345678 11111111 23456789
D fedcba98 01234567 ffffffff
D 0000ffff 00000001 00010000
J 00f3000d 13 2
D 7777a001 8888b001 b001a001
D 7777a002 8888b002 b002a002
D 7777a003 8888b003 b003a003
D 7777a004 8888b004 b004a004
D 7777a005 8888b005 b005a005
D 7777a006 8888b006 b006a006
D 7777a007 8888b007 b007a007
D 7777a008 8888b008 b008a008
D 7777a009 8888b009 b009a009
D 7777a00a 8888b00a b00aa00a
D 7777a00b 8888b00b b00ba00b
D 7777a00c 8888b00c b00ca00c
D 7777a00d 8888b00d b00da00d
J 00010000 0 0

//--- project.f
common/merge_pkg.sv
hw/merge_fifo.sv
merge_engine/merge_count_timer.sv
merge_engine/merge_data_path.sv
merge_engine/merge_control_fsm.sv
hw/merge_data_engine.sv
testbench/tb_merge_data_engine.sv
